// ==== flist.f ====
src/bus_pkg.sv
src/periph_pkg.sv
src/data_mem.sv
src/io_regs.sv
src/timer_regs.sv
src/timer_core.sv
src/minirisc_periph_top.sv
sim/periph_chk.sv
sim/tb_minirisc_periph.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_minirisc_periph -f flist.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vtb_minirisc_periph
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

// ==== sim/periph_chk.sv ====
/* Bus and timer assertions
   Bound into the peripheral top level */
`default_nettype none

module periph_chk (
   input logic              clk,
   input logic              arst_n,
   input bus_pkg::mst2slv_t bus,
   input logic              irq,
   input logic              ie,        // Timer interrupt enable bit
   input logic              expire     // Counter expiry pulse
);
   timeunit 1ns;
   timeprecision 1ps;

   //**************************************************************************
   // Bus protocol
   //**************************************************************************
   // Single master never strobes both ways
   wr_rd_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(bus.wr && bus.rd))
      else $error("wr and rd were high in the same cycle");

   //**************************************************************************
   // Timer
   //**************************************************************************
   irq_needs_ie: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(irq) |-> ie)
      else $error("irq rose while the interrupt enable was clear");

   expire_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      expire |=> !expire)              // Pulse, never a level
      else $error("expire stayed high for more than one cycle");

endmodule

`default_nettype wire

// ==== sim/tb_minirisc_periph.sv ====
/* Peripheral bus testbench
   Random master traffic checked each cycle against a model of the slaves */
`default_nettype none

module tb_minirisc_periph;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   localparam int N_PHASES     = 8;     // Four prescaler codes with IE set then clear
   localparam int PHASE_CYCLES = 2600;  // Longer than the slowest expiry
   localparam int IRQ_CYCLES   = 5;     // Two timer writes and three idle cycles
   localparam int MEM_WORDS    = 128;
   localparam int GPIO_W       = 8;
   localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + N_PHASES * (PHASE_CYCLES + 2) + IRQ_CYCLES;
   localparam bus_pkg::addr_t TMR_CTRL_ADDR = periph_pkg::TMR_BASE + periph_pkg::TMR_REG_CTRL;

   logic              clk = 1'b0;
   logic              arst_n;
   bus_pkg::mst2slv_t bus;
   bus_pkg::data_t    rdata;
   logic              irq;
   bus_pkg::data_t    sw;
   bus_pkg::data_t    ld;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;
   logic [GPIO_W-1:0] gpio_oe;

   integer seed      = 32'h349a_343c;
   string  test_name = "reset";

   //**************************************************************************
   // Reference model state
   //**************************************************************************
   bus_pkg::data_t         m_mem [MEM_WORDS] = '{default: '0};
   bus_pkg::data_t         m_led;
   bus_pkg::data_t         m_out;
   bus_pkg::data_t         m_dir;
   bus_pkg::data_t         m_reload;
   bus_pkg::data_t         m_count;
   logic                   m_en;
   logic                   m_ie;
   logic                   m_flag;
   periph_pkg::presc_sel_t m_ps;
   int                     m_presc;            // Clocks seen since the last load

   minirisc_periph_top #(.MEM_WORDS(MEM_WORDS)) dut0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus      (bus),
      .rdata    (rdata),
      .irq      (irq),
      .sw       (sw),
      .ld       (ld),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .gpio_oe  (gpio_oe)
   );

   bind minirisc_periph_top periph_chk chk0 (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (bus),
      .irq    (irq),
      .ie     (tmr_regs0.ie_q),
      .expire (tmr_expire)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_on_error(input string why);
      $display(">>> FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check_data(input string name, input bus_pkg::data_t exp,
                             input bus_pkg::data_t act);
      if (act !== exp)
      begin
         $display("FAIL %s %s: expected %h actual %h", test_name, name, exp, act);
         stop_on_error($sformatf("Wrong value on %s", name));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("FAIL %s %s: expected %b actual %b", test_name, name, exp, act);
         stop_on_error($sformatf("Wrong level on %s", name));
      end
   endtask

   task automatic check_byte_vec(input string name, input logic [GPIO_W-1:0] exp,
                                 input logic [GPIO_W-1:0] act);
      if (act !== exp)
      begin
         $display("FAIL %s %s: expected %h actual %h", test_name, name, exp, act);
         stop_on_error($sformatf("Wrong pin vector on %s", name));
      end
   endtask

   //**************************************************************************
   // Model update from the access that each clock edge ends
   //**************************************************************************
   // Memory keeps its contents through reset
   task automatic reset_model();
      m_led    = '0;
      m_out    = '0;
      m_dir    = '0;
      m_reload = '0;
      m_count  = '0;
      m_en     = 1'b0;
      m_ie     = 1'b0;
      m_flag   = 1'b0;
      m_ps     = '0;
      m_presc  = 0;
   endtask

   task automatic update_model();
      logic           cnt_wr;
      logic           ctrl_wr;
      logic           load;
      logic           tick;
      logic           expire;
      bus_pkg::data_t load_val;
      int             div;
      if (!arst_n)
         reset_model();
      else
      begin
         case (m_ps)
            2'd0:    div = 1;
            2'd1:    div = 16;
            2'd2:    div = 64;
            default: div = 256;
         endcase
         cnt_wr   = bus.wr && bus.addr == periph_pkg::TMR_BASE;
         ctrl_wr  = bus.wr && bus.addr == TMR_CTRL_ADDR;
         load     = cnt_wr || (ctrl_wr && bus.wdata[periph_pkg::CTRL_EN]);
         load_val = cnt_wr ? bus.wdata : m_reload;   // Fresh COUNT data is used at once
         tick     = m_en && (m_presc % div == div - 1);
         expire   = tick && m_count == 8'd0 && !load;
         if (load)
         begin
            m_count = load_val;
            m_presc = 0;                             // Full prescaler period after load
         end
         else
         begin
            if (tick)
               m_count = (m_count == 8'd0) ? m_reload : m_count - 8'd1;
            if (m_en)
               m_presc = (m_presc + 1) % 256;
         end
         if (expire)
            m_flag = 1'b1;
         else if (bus.rd && bus.addr == TMR_CTRL_ADDR)
            m_flag = 1'b0;                           // Status read clears
         if (cnt_wr)
            m_reload = bus.wdata;
         if (ctrl_wr)
         begin
            m_en = bus.wdata[periph_pkg::CTRL_EN];
            m_ie = bus.wdata[periph_pkg::CTRL_IE];
            m_ps = bus.wdata[periph_pkg::CTRL_PS_LO +: 2];
         end
         if (bus.wr && int'(bus.addr) < MEM_WORDS)
            m_mem[int'(bus.addr)] = bus.wdata;
         if (bus.wr && bus.addr == periph_pkg::LED_ADDR)
            m_led = bus.wdata;
         if (bus.wr && bus.addr == periph_pkg::GPIO_BASE + periph_pkg::GPIO_REG_OUT)
            m_out = bus.wdata;
         if (bus.wr && bus.addr == periph_pkg::GPIO_BASE + periph_pkg::GPIO_REG_DIR)
            m_dir = bus.wdata;
      end
   endtask

   // Read data the model expects in the current cycle
   function automatic bus_pkg::data_t expect_rdata();
      bus_pkg::data_t r;
      r = '0;
      if (bus.rd)
      begin
         if (int'(bus.addr) < MEM_WORDS)
            r = m_mem[int'(bus.addr)];
         else if (bus.addr == periph_pkg::LED_ADDR)
            r = m_led;
         else if (bus.addr == periph_pkg::DIP_ADDR)
            r = sw;                                  // Switches of this very cycle
         else if (bus.addr == periph_pkg::GPIO_BASE + periph_pkg::GPIO_REG_OUT)
            r = m_out;
         else if (bus.addr == periph_pkg::GPIO_BASE + periph_pkg::GPIO_REG_DIR)
            r = m_dir;
         else if (bus.addr == periph_pkg::GPIO_BASE + periph_pkg::GPIO_REG_IN)
            r = (m_out & m_dir) | (gpio_in & ~m_dir);
         else if (bus.addr == periph_pkg::TMR_BASE)
            r = m_count;
         else if (bus.addr == TMR_CTRL_ADDR)
         begin
            r[periph_pkg::CTRL_EN]      = m_en;
            r[periph_pkg::CTRL_IE]      = m_ie;
            r[periph_pkg::CTRL_PS_LO +: 2] = m_ps;
            r[periph_pkg::STAT_FLAG]    = m_flag;
         end
      end
      return r;
   endfunction

   //**************************************************************************
   // Stimulus
   //**************************************************************************
   // Weighted toward memory with timer reads only
   task automatic make_access(output bus_pkg::mst2slv_t acc);
      int unsigned pick;
      int unsigned op;
      pick      = $unsigned($random(seed)) % 16;
      op        = $unsigned($random(seed)) % 4;
      acc.wdata = bus_pkg::data_t'($random(seed));
      acc.wr    = op == 1;                           // 0 idle, 1 write, 2 and 3 read
      acc.rd    = op >= 2;
      if (pick < 7)
         acc.addr = bus_pkg::addr_t'($unsigned($random(seed)) % MEM_WORDS);
      else if (pick == 7)
         acc.addr = periph_pkg::LED_ADDR;
      else if (pick == 8)
         acc.addr = periph_pkg::DIP_ADDR;
      else if (pick < 13)
         acc.addr = periph_pkg::GPIO_BASE + bus_pkg::addr_t'(pick - 9);
      else if (pick == 13)
      begin
         acc.wr   = 1'b0;
         acc.rd   = 1'b1;
         acc.addr = ($unsigned($random(seed)) % 4 == 0) ? TMR_CTRL_ADDR : periph_pkg::TMR_BASE;
      end
      else if (pick == 14)
         acc.addr = 8'hC0 | bus_pkg::addr_t'($random(seed) & 32'h3F);  // Unmapped
      else
      begin
         acc.addr = bus_pkg::addr_t'($random(seed));   // Anywhere, map holes included
         acc.wr   = 1'b0;                               // Read or idle only
      end
   endtask

   // Drive at the rising edge and check at the falling edge
   task automatic run_cycle(input bus_pkg::mst2slv_t acc, input logic rst_n_next);
      @(posedge clk);
      update_model();
      arst_n  <= rst_n_next;
      bus     <= acc;
      sw      <= bus_pkg::data_t'($random(seed));
      gpio_in <= GPIO_W'($random(seed));
      @(negedge clk);
      if (!arst_n)
         reset_model();                              // Asynchronous reset acts at once
      check_data("rdata", expect_rdata(), rdata);
      check_bit("irq", m_flag && m_ie, irq);
      check_byte_vec("ld", m_led, ld);
      check_byte_vec("gpio_out", m_out, gpio_out);
      check_byte_vec("gpio_oe", m_dir, gpio_oe);
   endtask

   initial
   begin
      bus_pkg::mst2slv_t      acc;
      periph_pkg::presc_sel_t ps;
      logic                   ie;
      arst_n  <= 1'b0;
      bus     <= '0;
      sw      <= '0;
      gpio_in <= '0;
      for (int i = 0; i < RESET_CYCLES; i++)
         run_cycle('0, 1'b0);                        // Outputs must read zero
      for (int p = 0; p < N_PHASES; p++)
      begin
         ps        = periph_pkg::presc_sel_t'(p % 4);
         ie        = p < 4;
         test_name = $sformatf("timer_ps%0d_ie%0d", ps, ie);
         acc       = '0;
         acc.addr  = periph_pkg::TMR_BASE;           // Reload of 1..8 restarts the count
         acc.wr    = 1'b1;
         acc.wdata = bus_pkg::data_t'(1 + $unsigned($random(seed)) % 8);
         run_cycle(acc, 1'b1);
         acc.addr  = TMR_CTRL_ADDR;
         acc.wdata = bus_pkg::data_t'($random(seed));   // Spare bits stay random
         acc.wdata[periph_pkg::CTRL_EN]      = 1'b1;
         acc.wdata[periph_pkg::CTRL_IE]      = ie;
         acc.wdata[periph_pkg::CTRL_PS_LO +: 2] = ps;
         run_cycle(acc, 1'b1);
         for (int c = 0; c < PHASE_CYCLES; c++)
         begin
            make_access(acc);
            run_cycle(acc, 1'b1);
         end
      end

      // Raise irq, then reset with outputs and irq active
      test_name = "irq_reset";
      acc       = '0;
      acc.addr  = periph_pkg::TMR_BASE;              // Reload of 1 at the fastest rate
      acc.wr    = 1'b1;
      acc.wdata = 8'd1;
      run_cycle(acc, 1'b1);
      acc.addr  = TMR_CTRL_ADDR;
      acc.wdata = '0;
      acc.wdata[periph_pkg::CTRL_EN] = 1'b1;
      acc.wdata[periph_pkg::CTRL_IE] = 1'b1;
      run_cycle(acc, 1'b1);
      for (int c = 0; c < IRQ_CYCLES - 2; c++)
         run_cycle('0, 1'b1);                        // Count 1, then 0, then expiry
      check_bit("irq", 1'b1, irq);
      for (int i = 0; i < RESET_CYCLES; i++)
         run_cycle('0, 1'b0);                        // Everything but memory clears
      $display(">>> PASS");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(TOTAL_CYCLES * CLK_PERIOD * 2);
      stop_on_error("The test sequence did not finish before the watchdog expired");
   end

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
/* Data memory bus definitions
   Address and data vectors and the master-to-slave strobe bundle */
`default_nettype none

package bus_pkg;

   //**************************************************************************
   // Bus vectors
   //**************************************************************************
   typedef logic [7:0] addr_t;         // One word of address space
   typedef logic [7:0] data_t;         // One data byte

   //**************************************************************************
   // Master to slave bundle
   //**************************************************************************
   // Plain strobes with no handshake
   // At most one of wr and rd is high in a cycle
   typedef struct packed {
      addr_t addr;                     // Word address
      logic  wr;                       // Write strobe, one clock per write
      logic  rd;                       // Read strobe, data back in the same cycle
      data_t wdata;                    // Write data
   } mst2slv_t;                        // 18 bits

endpackage

`default_nettype wire

// ==== src/data_mem.sv ====
/* Data memory slave
   MEM_WORDS x 8 RAM above MEM_BASE with clocked write and combinational read */
`default_nettype none

module data_mem #(
   parameter int MEM_WORDS = 128          // Up to 256 words
) (
   input  logic              clk,
   input  bus_pkg::mst2slv_t bus,         // Shared master bus
   output bus_pkg::data_t    rdata        // Zero unless selected and read
);

   localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   //**************************************************************************
   // Storage
   //**************************************************************************
   // Powers up cleared
   bus_pkg::data_t mem [MEM_WORDS] = '{default: '0};

   bus_pkg::addr_t offs;                  // Address relative to the memory base
   logic [AW-1:0]  idx;
   logic           sel;

   // Address decode
   assign offs = bus.addr - periph_pkg::MEM_BASE;
   assign sel  = 32'(offs) < MEM_WORDS;   // Wraps below the base so one compare is enough
   assign idx  = offs[AW-1:0];

   // Write lands at the edge that ends the wr cycle
   always_ff @(posedge clk)
   begin
      if (sel && bus.wr)
         mem[idx] <= bus.wdata;
   end

   // Read shows contents from before this cycle's edge
   assign rdata = (sel && bus.rd) ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== src/io_regs.sv ====
/* Simple I/O slave
   LED output register, DIP switch input and one GPIO port with direction control */
`default_nettype none

module io_regs #(
   parameter bus_pkg::addr_t LED_ADDR  = 8'h80,
   parameter bus_pkg::addr_t DIP_ADDR  = 8'h81,
   parameter bus_pkg::addr_t GPIO_BASE = 8'hA0
) (
   input  logic              clk,
   input  logic              arst_n,
   input  bus_pkg::mst2slv_t bus,
   output bus_pkg::data_t    rdata,
   input  bus_pkg::data_t    sw,          // DIP switches
   output bus_pkg::data_t    ld,          // LEDs
   input  bus_pkg::data_t    gpio_in,     // Pin input values
   output bus_pkg::data_t    gpio_out,    // Pin output values
   output bus_pkg::data_t    gpio_oe      // Pin drive enables
);

   localparam bus_pkg::addr_t GPIO_SPAN = 8'd4;  // Four register slots

   bus_pkg::data_t led_q;
   bus_pkg::data_t out_q;                 // GPIO output data
   bus_pkg::data_t dir_q;                 // GPIO direction, 1 drives
   bus_pkg::data_t pad;                   // What the pins actually carry
   bus_pkg::addr_t gpio_offs;
   logic           led_sel;
   logic           dip_sel;
   logic           gpio_sel;

   //**************************************************************************
   // Decode
   //**************************************************************************
   assign led_sel   = bus.addr == LED_ADDR;
   assign dip_sel   = bus.addr == DIP_ADDR;
   assign gpio_offs = bus.addr - GPIO_BASE;
   assign gpio_sel  = gpio_offs < GPIO_SPAN;

   // Registers, writes to DIP and the GPIO input slot fall through
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         led_q <= '0;
         out_q <= '0;
         dir_q <= '0;                     // All pins inputs after reset
      end
      else if (bus.wr)
      begin
         if (led_sel)
            led_q <= bus.wdata;
         if (gpio_sel && gpio_offs == periph_pkg::GPIO_REG_OUT)
            out_q <= bus.wdata;
         if (gpio_sel && gpio_offs == periph_pkg::GPIO_REG_DIR)
            dir_q <= bus.wdata;
      end
   end

   // Driven bits loop back the output, the rest come from outside
   assign pad = (out_q & dir_q) | (gpio_in & ~dir_q);

   //**************************************************************************
   // Readback
   //**************************************************************************
   always_comb
   begin
      rdata = '0;
      if (bus.rd)
      begin
         if (led_sel)
            rdata = led_q;
         else if (dip_sel)
            rdata = sw;                   // Live switch value
         else if (gpio_sel)
         begin
            case (gpio_offs)
               periph_pkg::GPIO_REG_OUT: rdata = out_q;
               periph_pkg::GPIO_REG_DIR: rdata = dir_q;
               periph_pkg::GPIO_REG_IN:  rdata = pad;
               default:                  rdata = '0;   // Offset 3 unused
            endcase
         end
      end
   end

   assign ld       = led_q;
   assign gpio_out = out_q;
   assign gpio_oe  = dir_q;

endmodule

`default_nettype wire

// ==== src/minirisc_periph_top.sv ====
/* MiniRISC data bus peripheral subsystem
   Data memory, LED, DIP, timer and GPIO slaves on one bus with an OR read path */
`default_nettype none

module minirisc_periph_top #(
   parameter int             MEM_WORDS = 128,
   parameter bus_pkg::addr_t TMR_BASE  = periph_pkg::TMR_BASE,
   parameter bus_pkg::addr_t GPIO_BASE = periph_pkg::GPIO_BASE,
   parameter bus_pkg::addr_t LED_ADDR  = periph_pkg::LED_ADDR,
   parameter bus_pkg::addr_t DIP_ADDR  = periph_pkg::DIP_ADDR,
   parameter int             GPIO_W    = 8   // Fixed, equals the bus byte
) (
   input  logic              clk,
   input  logic              arst_n,
   input  bus_pkg::mst2slv_t bus,         // From the single master
   output bus_pkg::data_t    rdata,       // OR of all slave returns
   output logic              irq,         // Timer is the only source
   input  bus_pkg::data_t    sw,
   output bus_pkg::data_t    ld,
   input  logic [GPIO_W-1:0] gpio_in,
   output logic [GPIO_W-1:0] gpio_out,
   output logic [GPIO_W-1:0] gpio_oe
);

   // GPIO pins map one to one onto register bits
   if (GPIO_W != $bits(bus_pkg::data_t))
   begin : gen_gpio_w_check
      $error("GPIO_W must stay at the bus data width");
   end

   bus_pkg::data_t         mem_rdata;
   bus_pkg::data_t         io_rdata;
   bus_pkg::data_t         tmr_rdata;
   logic                   tmr_load;
   bus_pkg::data_t         tmr_reload;
   logic                   tmr_run;
   periph_pkg::presc_sel_t tmr_presc_sel;
   bus_pkg::data_t         tmr_count;
   logic                   tmr_expire;

   //**************************************************************************
   // Slaves
   //**************************************************************************
   data_mem #(.MEM_WORDS(MEM_WORDS)) mem0 (
      .clk   (clk),
      .bus   (bus),
      .rdata (mem_rdata)
   );

   io_regs #(
      .LED_ADDR  (LED_ADDR),
      .DIP_ADDR  (DIP_ADDR),
      .GPIO_BASE (GPIO_BASE)
   ) io0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus      (bus),
      .rdata    (io_rdata),
      .sw       (sw),
      .ld       (ld),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .gpio_oe  (gpio_oe)
   );

   timer_regs #(.TMR_BASE(TMR_BASE)) tmr_regs0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .bus       (bus),
      .rdata     (tmr_rdata),
      .count     (tmr_count),
      .expire    (tmr_expire),
      .load      (tmr_load),
      .reload    (tmr_reload),
      .run       (tmr_run),
      .presc_sel (tmr_presc_sel),
      .irq       (irq)
   );

   timer_core tmr_core0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .load      (tmr_load),
      .reload    (tmr_reload),
      .run       (tmr_run),
      .presc_sel (tmr_presc_sel),
      .count     (tmr_count),
      .expire    (tmr_expire)
   );

   // Unselected slaves return zero so a plain OR merges them
   assign rdata = mem_rdata | io_rdata | tmr_rdata;

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
/* Peripheral map definitions
   Default slave addresses, register offsets and timer control bits */
`default_nettype none

package periph_pkg;

   //**************************************************************************
   // Address map defaults
   //**************************************************************************
   localparam bus_pkg::addr_t MEM_BASE  = 8'h00;  // Data memory 0x00..0x7F
   localparam bus_pkg::addr_t LED_ADDR  = 8'h80;  // LED register
   localparam bus_pkg::addr_t DIP_ADDR  = 8'h81;  // DIP switches, read only
   localparam bus_pkg::addr_t TMR_BASE  = 8'h82;  // Timer 0x82..0x83
   localparam bus_pkg::addr_t GPIO_BASE = 8'hA0;  // GPIO 0xA0..0xA3

   // Timer register offsets
   localparam bus_pkg::addr_t TMR_REG_COUNT = 8'd0;  // Reload on write, count on read
   localparam bus_pkg::addr_t TMR_REG_CTRL  = 8'd1;  // Control on write, status on read

   // GPIO register offsets
   localparam bus_pkg::addr_t GPIO_REG_OUT = 8'd0;
   localparam bus_pkg::addr_t GPIO_REG_DIR = 8'd1;   // 1 drives the pin
   localparam bus_pkg::addr_t GPIO_REG_IN  = 8'd2;   // Pad value

   //**************************************************************************
   // Timer control and status bits
   //**************************************************************************
   localparam int unsigned CTRL_EN    = 0;  // Count enable
   localparam int unsigned CTRL_IE    = 1;  // Interrupt enable
   localparam int unsigned CTRL_PS_LO = 4;  // Prescaler select, two bits
   localparam int unsigned STAT_FLAG  = 7;  // Expiry flag in status

   typedef logic [1:0] presc_sel_t;  // 0 1 2 3 give /1 /16 /64 /256
   typedef logic [7:0] presc_cnt_t;  // Free running prescaler

   // Low prescaler bits that must all be ones for a tick
   function automatic presc_cnt_t presc_mask(presc_sel_t sel);
      case (sel)
         2'd0:    presc_mask = 8'h00;  // Every clock
         2'd1:    presc_mask = 8'h0F;  // Every 16 clocks
         2'd2:    presc_mask = 8'h3F;  // Every 64 clocks
         default: presc_mask = 8'hFF;  // Every 256 clocks
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== src/timer_core.sv ====
/* Timer counting core
   Prescaler tick generator and 8-bit auto-reloading down-counter */
`default_nettype none

module timer_core (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,       // Restart from reload
   input  bus_pkg::data_t         reload,
   input  logic                   run,        // Count enable
   input  periph_pkg::presc_sel_t presc_sel,
   output bus_pkg::data_t         count,
   output logic                   expire      // Tick seen with count at zero
);

   periph_pkg::presc_cnt_t presc_q;
   periph_pkg::presc_cnt_t mask;
   bus_pkg::data_t         count_q;
   logic                   tick;

   //**************************************************************************
   // Prescaler
   //**************************************************************************
   assign mask = periph_pkg::presc_mask(presc_sel);
   assign tick = run && ((presc_q & mask) == mask);  // Low bits all ones

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         presc_q <= '0;
      else if (load)
         presc_q <= '0;                   // Full period after every load
      else if (run)
         presc_q <= presc_q + periph_pkg::presc_cnt_t'(1);
   end

   //**************************************************************************
   // Down-counter
   //**************************************************************************
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         count_q <= '0;
      else if (load)
         count_q <= reload;
      else if (tick)
      begin
         if (count_q == '0)
            count_q <= reload;            // Auto reload on expiry
         else
            count_q <= count_q - bus_pkg::data_t'(1);
      end
   end

   assign count  = count_q;
   assign expire = tick && (count_q == '0) && !load;  // Load wins over expiry

endmodule

`default_nettype wire

// ==== src/timer_regs.sv ====
/* Timer register block
   Reload and control registers, expiry flag and the level interrupt */
`default_nettype none

module timer_regs #(
   parameter bus_pkg::addr_t TMR_BASE = 8'h82
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  bus_pkg::mst2slv_t      bus,
   output bus_pkg::data_t         rdata,
   input  bus_pkg::data_t         count,      // Live counter value
   input  logic                   expire,     // One clock per expiry
   output logic                   load,       // Restart the counter this edge
   output bus_pkg::data_t         reload,     // Value taken on load or expiry
   output logic                   run,
   output periph_pkg::presc_sel_t presc_sel,
   output logic                   irq
);

   localparam int PSW = $bits(periph_pkg::presc_sel_t);

   bus_pkg::addr_t         offs;
   logic                   cnt_sel;
   logic                   ctrl_sel;
   logic                   cnt_wr;
   logic                   ctrl_wr;
   logic                   ctrl_rd;
   bus_pkg::data_t         reload_q;
   logic                   en_q;
   logic                   ie_q;
   periph_pkg::presc_sel_t ps_q;
   logic                   flag_q;        // Sticky until status is read
   bus_pkg::data_t         status;

   //**************************************************************************
   // Decode
   //**************************************************************************
   assign offs     = bus.addr - TMR_BASE;
   assign cnt_sel  = offs == periph_pkg::TMR_REG_COUNT;
   assign ctrl_sel = offs == periph_pkg::TMR_REG_CTRL;
   assign cnt_wr   = bus.wr && cnt_sel;
   assign ctrl_wr  = bus.wr && ctrl_sel;
   assign ctrl_rd  = bus.rd && ctrl_sel;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         reload_q <= '0;
         en_q     <= 1'b0;
         ie_q     <= 1'b0;
         ps_q     <= '0;
         flag_q   <= 1'b0;
      end
      else
      begin
         if (cnt_wr)
            reload_q <= bus.wdata;
         if (ctrl_wr)
         begin
            // Only EN, IE and the prescaler select are stored
            en_q <= bus.wdata[periph_pkg::CTRL_EN];
            ie_q <= bus.wdata[periph_pkg::CTRL_IE];
            ps_q <= bus.wdata[periph_pkg::CTRL_PS_LO +: PSW];
         end
         if (expire)
            flag_q <= 1'b1;               // New expiry beats a clearing read
         else if (ctrl_rd)
            flag_q <= 1'b0;
      end
   end

   // Status image with control bits in their write positions
   always_comb
   begin
      status = '0;
      status[periph_pkg::CTRL_EN]             = en_q;
      status[periph_pkg::CTRL_IE]             = ie_q;
      status[periph_pkg::CTRL_PS_LO +: PSW]   = ps_q;
      status[periph_pkg::STAT_FLAG]           = flag_q;
   end

   assign rdata = !bus.rd  ? '0     :
                  cnt_sel  ? count  :
                  ctrl_sel ? status : '0;

   //**************************************************************************
   // Counter controls
   //**************************************************************************
   // COUNT write or enabling write restarts the count
   assign load      = cnt_wr || (ctrl_wr && bus.wdata[periph_pkg::CTRL_EN]);
   // Fresh COUNT data goes straight through so the load uses it
   assign reload    = cnt_wr ? bus.wdata : reload_q;
   assign run       = en_q;
   assign presc_sel = ps_q;
   assign irq       = flag_q && ie_q;    // Level, drops on the clearing read

endmodule

`default_nettype wire
